/* tb/key_vectors.txt */
// Columns: key, dir (1 = encrypt, 0 = decrypt), then round keys 1 to 16 in output order
// Decrypt lines list the encryption keys of that key in reverse
133457799BBCDFF1 1 1B02EFFC7072 79AED9DBC9E5 55FC8A42CF99 72ADD6DB351D 7CEC07EB53A8 63A53E507B2F EC84B7F618BC F78A3AC13BFB E0DBEBEDE781 B1F347BA464F 215FD3DED386 7571F59467E9 97C5D1FABA41 5F43B7F2E73A BF918D3D3F0A CB3D8B0E17F5
133457799BBCDFF1 0 CB3D8B0E17F5 BF918D3D3F0A 5F43B7F2E73A 97C5D1FABA41 7571F59467E9 215FD3DED386 B1F347BA464F E0DBEBEDE781 F78A3AC13BFB EC84B7F618BC 63A53E507B2F 7CEC07EB53A8 72ADD6DB351D 55FC8A42CF99 79AED9DBC9E5 1B02EFFC7072
0101010101010101 1 000000000000 000000000000 000000000000 000000000000 000000000000 000000000000 000000000000 000000000000 000000000000 000000000000 000000000000 000000000000 000000000000 000000000000 000000000000 000000000000
FEFEFEFEFEFEFEFE 0 FFFFFFFFFFFF FFFFFFFFFFFF FFFFFFFFFFFF FFFFFFFFFFFF FFFFFFFFFFFF FFFFFFFFFFFF FFFFFFFFFFFF FFFFFFFFFFFF FFFFFFFFFFFF FFFFFFFFFFFF FFFFFFFFFFFF FFFFFFFFFFFF FFFFFFFFFFFF FFFFFFFFFFFF FFFFFFFFFFFF FFFFFFFFFFFF
1F1F1F1F0E0E0E0E 1 000000FFFFFF 000000FFFFFF 000000FFFFFF 000000FFFFFF 000000FFFFFF 000000FFFFFF 000000FFFFFF 000000FFFFFF 000000FFFFFF 000000FFFFFF 000000FFFFFF 000000FFFFFF 000000FFFFFF 000000FFFFFF 000000FFFFFF 000000FFFFFF

/* des_key_schedule.f */
verilog/des_pkg.sv
verilog/key_sched_fsm.sv
verilog/round_counter.sv
verilog/credit_counter.sv
verilog/cd_register.sv
verilog/subkey_compress.sv
verilog/des_key_schedule.sv
tb/clock_gen.sv
tb/des_key_schedule_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the DES key schedule testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --timescale 1ns/100ps --top-module des_key_schedule_tb \
	-f des_key_schedule.f
output=$(./obj_dir/Vdes_key_schedule_tb 2>&1) || true
echo "$output"
if echo "$output" | grep -q "Testbench passed"; then
	exit 0
fi
exit 1

/* tb/des_key_schedule_tb.sv */
// ##########################################################
// DES key schedule testbench: replays key vectors, returns
// credits after random delays and checks every round key
// ##########################################################
`timescale 1ns/100ps

module des_key_schedule_tb import des_pkg::*; ();

	localparam int NUM_VEC   = 5;
	localparam int VEC_WORDS = 18;

	logic        clk;
	logic        rst_n;
	key_t        key;
	key_dir_e    dir;
	logic        start;
	logic        ready;
	subkey_t     round_key;
	round_t      round_num;
	logic        round_key_valid;
	logic        credit_return;

	logic [63:0] vec_mem [0:NUM_VEC*VEC_WORDS-1];
	subkey_t     exp_keys[$];
	round_t      exp_rounds[$];
	// Keys held by the consumer and not yet returned as credit
	int          owed = 0;
	bit          fast_mode = 1'b0;
	logic [15:0] lfsr_state = 16'd61936;

	clock_gen u_clock_gen (.clk(clk), .rst_n(rst_n));

	des_key_schedule UUT (
		.clk             (clk),
		.rst_n           (rst_n),
		.key             (key),
		.dir             (dir),
		.start           (start),
		.ready           (ready),
		.round_key       (round_key),
		.round_num       (round_num),
		.round_key_valid (round_key_valid),
		.credit_return   (credit_return)
	);

	task automatic stop_run();
		$display("Testbench failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic abort_with_message(input string what);
		$display("%0t: %s", $time, what);
		stop_run();
	endtask

	task automatic check_subkey(input string name, input subkey_t got, input subkey_t exp);
		if (got !== exp) begin
			$display("ERR %0t %s got %h expected %h", $time, name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_round(input string name, input round_t got, input round_t exp);
		if (got !== exp) begin
			$display("ERR %0t %s got %0d expected %0d", $time, name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("ERR %0t %s got %b expected %b", $time, name, got, exp);
			stop_run();
		end
	endtask

	// Taps x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
	function automatic logic [7:0] random_bits(input int n);
		logic [7:0] bits;
		bits = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = {lfsr_state[14:0],
				lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10]};
			bits = {bits[6:0], lfsr_state[0]};
		end
		return bits;
	endfunction

	task automatic wait_for_ready();
		int n;
		n = 0;
		do begin
			@(negedge clk);
			n++;
			if (n > 50) abort_with_message("timed out waiting for ready");
		end while (!ready);
	endtask

	task automatic wait_for_drain();
		int n;
		n = 0;
		while (exp_keys.size() != 0) begin
			@(posedge clk);
			n++;
			if (n > 400) abort_with_message("timed out waiting for round keys, some never arrived");
		end
	endtask

	task automatic wait_for_credits();
		int n;
		n = 0;
		while (owed != 0) begin
			@(posedge clk);
			n++;
			if (n > 100) abort_with_message("timed out waiting for the consumer to return credits");
		end
		// Let the DUT count the last return
		repeat (2) @(posedge clk);
	endtask

	task automatic run_vector(input int v, input bit poke);
		int base;
		base = v * VEC_WORDS;
		for (int r = 1; r <= NUM_ROUNDS; r++) begin
			exp_keys.push_back(subkey_t'(vec_mem[base + 1 + r]));
			exp_rounds.push_back(round_t'(r));
		end
		wait_for_ready();
		@(posedge clk);
		key   <= vec_mem[base];
		dir   <= key_dir_e'(vec_mem[base + 1][0]);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		if (fast_mode) begin
			// First step runs in the cycle after acceptance and keys follow back to back
			@(negedge clk);
			check_flag("round_key_valid", round_key_valid, 1'b0);
			repeat (NUM_ROUNDS) begin
				@(negedge clk);
				check_flag("round_key_valid", round_key_valid, 1'b1);
			end
		end
		if (poke) begin
			@(negedge clk);
			check_flag("ready", ready, 1'b0);
			@(posedge clk);
			key   <= ~vec_mem[base];
			dir   <= (dir == DIR_ENCRYPT) ? DIR_DECRYPT : DIR_ENCRYPT;
			start <= 1'b1;
			@(posedge clk);
			start <= 1'b0;
		end
		wait_for_drain();
	endtask

	initial begin : monitor
		subkey_t exp_key;
		round_t  exp_round;
		forever begin
			@(negedge clk);
			if (rst_n && round_key_valid) begin
				if (exp_keys.size() == 0) abort_with_message("round key arrived with none expected");
				exp_key   = exp_keys.pop_front();
				exp_round = exp_rounds.pop_front();
				check_subkey("round_key", round_key, exp_key);
				check_round("round_num", round_num, exp_round);
				if (exp_round == round_t'(NUM_ROUNDS)) check_flag("ready", ready, 1'b1);
				owed++;
				if (owed > CREDITS) abort_with_message("consumer holds more keys than it has credits");
			end
		end
	end

	initial begin : consumer
		int hold;
		hold = -1;
		credit_return <= 1'b0;
		forever begin
			@(posedge clk);
			credit_return <= 1'b0;
			if (owed > 0) begin
				if (hold < 0) hold = fast_mode ? 0 : int'(random_bits(3));
				if (hold == 0) begin
					credit_return <= 1'b1;
					owed--;
					hold = -1;
				end else begin
					hold--;
				end
			end
		end
	end

	initial begin : main
		int n;
		key   <= '0;
		dir   <= DIR_ENCRYPT;
		start <= 1'b0;
		$readmemh("tb/key_vectors.txt", vec_mem);
		n = 0;
		do begin
			@(negedge clk);
			check_flag("round_key_valid", round_key_valid, 1'b0);
			check_flag("ready", ready, 1'b1);
			n++;
			if (n > 20) abort_with_message("timed out waiting for reset release");
		end while (!rst_n);
		for (int v = 0; v < NUM_VEC; v++) begin
			run_vector(v, v == 0);
		end
		wait_for_credits();
		fast_mode = 1'b1;
		run_vector(0, 1'b0);
		$display("Testbench passed");
		$finish;
	end

endmodule

/* tb/clock_gen.sv */
// ##########################################################
// Testbench clock and reset: 8 ns clock, reset low for
// the first 8 rising edges
// ##########################################################
`timescale 1ns/100ps

module clock_gen (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin
		rst_n <= 1'b0;
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

/* verilog/des_key_schedule.sv */
// ##########################################################
// DES key schedule top: sequential round key generator with
// start handshake and credit flow control to the consumer
// ##########################################################
`timescale 1ns/100ps

module des_key_schedule import des_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  key_t     key,
	input  key_dir_e dir,
	input  logic     start,
	output logic     ready,
	output subkey_t  round_key,
	output round_t   round_num,
	output logic     round_key_valid,
	input  logic     credit_return
);

	logic   load;
	logic   step;
	logic   credit_avail;
	logic   last_round;
	round_t round_cnt;
	cd_t    cd_round;

	key_sched_fsm u_fsm (
		.clk          (clk),
		.rst_n        (rst_n),
		.start        (start),
		.credit_avail (credit_avail),
		.last_round   (last_round),
		.ready        (ready),
		.load         (load),
		.step         (step)
	);

	round_counter u_round_counter (
		.clk        (clk),
		.rst_n      (rst_n),
		.load       (load),
		.step       (step),
		.round_num  (round_cnt),
		.last_round (last_round)
	);

	credit_counter u_credit_counter (
		.clk           (clk),
		.rst_n         (rst_n),
		.step          (step),
		.credit_return (credit_return),
		.credit_avail  (credit_avail)
	);

	cd_register u_cd_register (
		.clk       (clk),
		.rst_n     (rst_n),
		.load      (load),
		.step      (step),
		.key       (key),
		.dir       (dir),
		.round_num (round_cnt),
		.cd_round  (cd_round)
	);

	subkey_compress u_subkey_compress (
		.clk               (clk),
		.rst_n             (rst_n),
		.step              (step),
		.round_num         (round_cnt),
		.cd_round          (cd_round),
		.round_key         (round_key),
		.round_key_out_num (round_num),
		.round_key_valid   (round_key_valid)
	);

endmodule

/* verilog/subkey_compress.sv */
// ##########################################################
// Subkey compress: PC-2 down to 48 bits, registered with
// the round number and a one-cycle valid
// ##########################################################
`timescale 1ns/100ps

module subkey_compress import des_pkg::*; (
	input  logic    clk,
	input  logic    rst_n,
	input  logic    step,
	input  round_t  round_num,
	input  cd_t     cd_round,
	output subkey_t round_key,
	output round_t  round_key_out_num,
	output logic    round_key_valid
);

	subkey_t compressed;

	always_comb begin
		for (int i = 0; i < SUBKEY_W; i++) begin
			compressed[SUBKEY_W-1-i] = cd_round[PC2_TABLE[i]];
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			round_key_valid <= 1'b0;
		end else begin
			round_key_valid <= step;
		end
	end

	// Held between steps so a stalled consumer sees a stable key
	always_ff @(posedge clk) begin
		if (step) begin
			round_key         <= compressed;
			round_key_out_num <= round_num;
		end
	end

endmodule

/* verilog/cd_register.sv */
// ##########################################################
// CD register: PC-1 of the key, then per-round rotation of
// the C and D halves, left for encryption, right for decryption
// ##########################################################
`timescale 1ns/100ps

module cd_register import des_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     load,
	input  logic     step,
	input  key_t     key,
	input  key_dir_e dir,
	input  round_t   round_num,
	output cd_t      cd_round
);

	cd_t             cd_q;
	key_dir_e        dir_q;
	logic [3:0]      enc_idx;
	logic [3:0]      dec_idx;
	logic [1:0]      shift;

	function automatic cd_t pc1(input key_t k);
		cd_t p;
		for (int i = 0; i < CD_W; i++) begin
			p[CD_W-1-i] = k[PC1_TABLE[i]];
		end
		return p;
	endfunction

	function automatic logic [HALF_W-1:0] rotl(input logic [HALF_W-1:0] h, input logic [1:0] n);
		logic [2*HALF_W-1:0] dbl;
		dbl = {h, h} << n;
		return dbl[2*HALF_W-1:HALF_W];
	endfunction

	function automatic logic [HALF_W-1:0] rotr(input logic [HALF_W-1:0] h, input logic [1:0] n);
		logic [2*HALF_W-1:0] dbl;
		dbl = {h, h} >> n;
		return dbl[HALF_W-1:0];
	endfunction

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			dir_q <= DIR_ENCRYPT;
		end else if (load) begin
			dir_q <= dir;
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			cd_q <= pc1(key);
		end else if (step) begin
			cd_q <= cd_round;
		end
	end

	// Table index r-1 going forward, 17-r going backward (mod 16)
	assign enc_idx = round_num[3:0] - 4'd1;
	assign dec_idx = 4'd1 - round_num[3:0];

	always_comb begin
		shift = 2'd0;
		if (dir_q == DIR_ENCRYPT) begin
			shift = 2'(SHIFT_TABLE[enc_idx]);
		end else if (round_num != round_t'(1)) begin
			shift = 2'(SHIFT_TABLE[dec_idx]);
		end
	end

	// Round 1 of decryption reuses C0D0, which equals C16D16
	assign cd_round = (dir_q == DIR_ENCRYPT) ?
		{rotl(cd_q[CD_W-1:HALF_W], shift), rotl(cd_q[HALF_W-1:0], shift)} :
		{rotr(cd_q[CD_W-1:HALF_W], shift), rotr(cd_q[HALF_W-1:0], shift)};

endmodule

/* verilog/credit_counter.sv */
// ##########################################################
// Credit counter: free slots left at the key consumer
// ##########################################################
`timescale 1ns/100ps

module credit_counter import des_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	input  logic step,
	input  logic credit_return,
	output logic credit_avail
);

	credit_t count;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			count <= credit_t'(CREDITS);
		end else begin
			case ({step, credit_return})
				2'b10:   count <= count - credit_t'(1);
				2'b01:   count <= count + credit_t'(1);
				// Issue and return in one cycle cancel out
				default: count <= count;
			endcase
		end
	end

	assign credit_avail = (count != '0);

endmodule

/* verilog/round_counter.sv */
// ##########################################################
// Round counter: runs 1 to 16, flags the final round
// ##########################################################
`timescale 1ns/100ps

module round_counter import des_pkg::*; (
	input  logic   clk,
	input  logic   rst_n,
	input  logic   load,
	input  logic   step,
	output round_t round_num,
	output logic   last_round
);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			round_num <= '0;
		end else if (load) begin
			round_num <= round_t'(1);
		end else if (step) begin
			round_num <= round_num + round_t'(1);
		end
	end

	assign last_round = (round_num == round_t'(NUM_ROUNDS));

endmodule

/* verilog/key_sched_fsm.sv */
// ##########################################################
// Key schedule FSM: accepts a key and issues one round per
// cycle while the consumer has credit
// ##########################################################
`timescale 1ns/100ps

module key_sched_fsm import des_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	input  logic start,
	input  logic credit_avail,
	input  logic last_round,
	output logic ready,
	output logic load,
	output logic step
);

	sched_state_e state;
	sched_state_e next_state;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= SCHED_IDLE;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			SCHED_IDLE: begin
				if (start) begin
					next_state = SCHED_RUN;
				end
			end
			SCHED_RUN: begin
				// Back to idle once round 16 has gone out
				if (step && last_round) begin
					next_state = SCHED_IDLE;
				end
			end
			default: next_state = SCHED_IDLE;
		endcase
	end

	assign ready = (state == SCHED_IDLE);
	assign load  = ready && start;
	assign step  = (state == SCHED_RUN) && credit_avail;

endmodule

/* verilog/des_pkg.sv */
// ##########################################################
// DES key schedule package: widths, types, PC-1 and PC-2
// tables, per-round shift amounts and consumer credit depth
// ##########################################################

package des_pkg;

	localparam int KEY_W      = 64;
	localparam int CD_W       = 56;
	localparam int HALF_W     = 28;
	localparam int SUBKEY_W   = 48;
	localparam int NUM_ROUNDS = 16;
	localparam int CREDITS    = 4;

	typedef logic [KEY_W-1:0]    key_t;
	typedef logic [CD_W-1:0]     cd_t;
	typedef logic [SUBKEY_W-1:0] subkey_t;
	typedef logic [4:0]          round_t;
	typedef logic [2:0]          credit_t;

	// 1 selects encryption order
	typedef enum logic {
		DIR_DECRYPT = 1'b0,
		DIR_ENCRYPT = 1'b1
	} key_dir_e;

	typedef enum logic {
		SCHED_IDLE,
		SCHED_RUN
	} sched_state_e;

	// Key bit feeding each CD bit, listed from the MSB down
	localparam int PC1_TABLE [0:CD_W-1] = '{
		7,  15, 23, 31, 39, 47, 55,
		63, 6,  14, 22, 30, 38, 46,
		54, 62, 5,  13, 21, 29, 37,
		45, 53, 61, 4,  12, 20, 28,
		1,  9,  17, 25, 33, 41, 49,
		57, 2,  10, 18, 26, 34, 42,
		50, 58, 3,  11, 19, 27, 35,
		43, 51, 59, 36, 44, 52, 60
	};

	// CD bit feeding each round key bit, MSB first
	localparam int PC2_TABLE [0:SUBKEY_W-1] = '{
		42, 39, 45, 32, 55, 51, 53, 28,
		41, 50, 35, 46, 33, 37, 44, 52,
		30, 48, 40, 49, 29, 36, 43, 54,
		15, 4,  25, 19, 9,  1,  26, 16,
		5,  11, 23, 8,  12, 7,  17, 0,
		22, 3,  10, 14, 6,  20, 27, 24
	};

	// Left rotation of each half in encryption rounds 1 to 16, sums to 28
	localparam int SHIFT_TABLE [0:NUM_ROUNDS-1] = '{
		1, 1, 2, 2, 2, 2, 2, 2,
		1, 2, 2, 2, 2, 2, 2, 1
	};

endpackage
